// File: src/pcie_tl_pkg.sv
`default_nettype none

package pcie_tl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths

	// One bus word per stream beat
	localparam int word_w = 32;
	// Byte lanes in a bus word
	localparam int strb_w = word_w / 8;
	// Config space register address
	localparam int cfg_addr_w = 12;
	// TLP length field, in words
	localparam int len_w = 10;

	// Poisoned flag in header word 0
	localparam int poison_bit = 22;
	// A config read always returns one full word
	localparam int cfg_rd_byte_count = 4;

	//////////////////////////////////////////////////////////////////////
	// Header field encodings

	typedef enum logic [2:0] {
		fmt_3dw_nodata = 3'd0,
		fmt_4dw_nodata = 3'd1,
		fmt_3dw_data   = 3'd2,
		fmt_4dw_data   = 3'd3
	} tlp_format_t;

	typedef enum logic [4:0] {
		type_mem        = 5'd0,
		type_mem_locked = 5'd1,
		type_io         = 5'd2,
		type_cfg0       = 5'd4,
		type_cfg1       = 5'd5,
		type_cpl        = 5'd10,
		type_cpl_locked = 5'd11
	} tlp_type_t;

	//////////////////////////////////////////////////////////////////////
	// Shared types

	typedef logic [word_w-1:0] tlp_word_t;
	typedef logic [cfg_addr_w-1:0] cfg_addr_t;

	// Function number is always zero, so it is not carried
	typedef struct packed {
		logic [7:0] bus;
		logic [4:0] dev;
	} completer_id_t;

	// Receive stream and memory write stream
	typedef struct packed {
		logic      valid;
		logic      last;
		logic      crc_err;
		tlp_word_t data;
	} tlp_stream_t;

	// Transmit stream, no sideband flags
	typedef struct packed {
		logic      valid;
		logic      last;
		tlp_word_t data;
	} tx_stream_t;

	// Parser to APB requester
	typedef struct packed {
		logic      start;
		logic      write;
		cfg_addr_t addr;
		tlp_word_t wdata;
	} apb_req_t;

	// Parser to completion generator
	typedef struct packed {
		logic             start;
		logic             with_data;
		logic [len_w-1:0] len;
		logic [15:0]      requester;
		logic [7:0]       tag;
		completer_id_t    cpl_id;
		tlp_word_t        rdata;
	} cpl_req_t;

endpackage

`default_nettype wire

// File: src/tlp_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_parser (
	input  wire                             axi_tlp_rx,
	input  wire                             rst_n,
	input  wire pcie_tl_pkg::tlp_stream_t   tlp_in,
	output logic                            tlp_in_ready,
	output pcie_tl_pkg::tlp_stream_t        mem_wr,
	output pcie_tl_pkg::apb_req_t           apb_req,
	input  wire                             apb_done,
	input  wire pcie_tl_pkg::tlp_word_t     apb_rdata,
	output pcie_tl_pkg::cpl_req_t           cpl_req,
	input  wire                             cpl_busy
);

	typedef enum logic [2:0] {
		st_idle,
		st_hdr1,
		st_hdr2,
		st_cfg_wdata,
		st_mem_wr,
		st_cfg_rd_wait,
		st_drop
	} rx_state_t;

	rx_state_t state;

	// Header fields, held until the completion has been latched
	pcie_tl_pkg::tlp_format_t        rx_fmt;
	pcie_tl_pkg::tlp_type_t          rx_type;
	logic [pcie_tl_pkg::len_w-1:0]   rx_len;
	logic [15:0]                     rx_requester;
	logic [7:0]                      rx_tag;
	pcie_tl_pkg::tlp_word_t          rx_addr;
	pcie_tl_pkg::completer_id_t      cpl_id;

	logic                            apb_start;
	logic                            apb_write;
	pcie_tl_pkg::tlp_word_t          apb_wdata;
	logic                            cpl_start;
	logic                            cpl_with_data;
	logic                            mem_valid;
	logic                            mem_last;
	logic                            mem_crc;
	pcie_tl_pkg::tlp_word_t          mem_data;

	logic                            rx_beat;
	pcie_tl_pkg::tlp_word_t          addr_swap;
	logic                            is_cfg_rd;
	logic                            is_cfg_wr;
	logic                            is_mem_wr;

	assign rx_beat = tlp_in.valid && tlp_in_ready;

	// Address word arrives with byte 0 most significant
	assign addr_swap = {tlp_in.data[7:0], tlp_in.data[15:8],
		tlp_in.data[23:16], tlp_in.data[31:24]};

	// Supported request kinds, decoded from the stored word 0
	assign is_cfg_rd = (rx_fmt == pcie_tl_pkg::fmt_3dw_nodata) &&
		(rx_type == pcie_tl_pkg::type_cfg0);
	assign is_cfg_wr = (rx_fmt == pcie_tl_pkg::fmt_3dw_data) &&
		(rx_type == pcie_tl_pkg::type_cfg0);
	assign is_mem_wr = (rx_fmt == pcie_tl_pkg::fmt_3dw_data) &&
		(rx_type == pcie_tl_pkg::type_mem);

	//////////////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge axi_tlp_rx or negedge rst_n) begin
		if (!rst_n) begin
			state         <= st_idle;
			tlp_in_ready  <= 1'b1;
			apb_start     <= 1'b0;
			apb_write     <= 1'b0;
			cpl_start     <= 1'b0;
			cpl_with_data <= 1'b0;
			mem_valid     <= 1'b0;
			mem_last      <= 1'b0;
			mem_crc       <= 1'b0;
			cpl_id        <= '0;
		end else begin
			// Strobes last one cycle
			apb_start <= 1'b0;
			cpl_start <= 1'b0;
			mem_valid <= 1'b0;
			mem_last  <= 1'b0;

			// Any accepted last beat ends the TLP unless a state says otherwise
			if (rx_beat && tlp_in.last)
				state <= st_idle;

			case (state)
				st_idle: begin
					// Stay closed while a completion is still going out
					tlp_in_ready <= !(cpl_busy || cpl_start);
					// A one-word TLP is malformed and simply ends here
					if (rx_beat && !tlp_in.last) begin
						if (tlp_in.data[pcie_tl_pkg::poison_bit])
							state <= st_drop;
						else
							state <= st_hdr1;
					end
				end

				st_hdr1: begin
					if (rx_beat && !tlp_in.last)
						state <= st_hdr2;
				end

				st_hdr2: begin
					if (rx_beat) begin
						if (tlp_in.last) begin
							// Header-only config read, go out on APB
							if (is_cfg_rd) begin
								apb_start    <= 1'b1;
								apb_write    <= 1'b0;
								tlp_in_ready <= 1'b0;
								state        <= st_cfg_rd_wait;
							end
						end else if (is_cfg_wr)
							state <= st_cfg_wdata;
						else if (is_mem_wr)
							state <= st_mem_wr;
						else
							// 4DW, unknown type, or read with trailing words
							state <= st_drop;
					end
				end

				st_cfg_wdata: begin
					if (rx_beat) begin
						// Exactly one data word is allowed
						if (!tlp_in.last)
							state <= st_drop;
						else if (!tlp_in.crc_err) begin
							apb_start     <= 1'b1;
							apb_write     <= 1'b1;
							cpl_start     <= 1'b1;
							cpl_with_data <= 1'b0;
							tlp_in_ready  <= 1'b0;
							// Bus and device come from the write's own address
							cpl_id.bus    <= rx_addr[31:24];
							cpl_id.dev    <= rx_addr[23:19];
						end
					end
				end

				st_mem_wr: begin
					if (rx_beat) begin
						mem_valid <= 1'b1;
						mem_last  <= tlp_in.last;
						mem_crc   <= tlp_in.crc_err;
						if (tlp_in.last) begin
							cpl_start     <= 1'b1;
							cpl_with_data <= 1'b0;
							tlp_in_ready  <= 1'b0;
						end
					end
				end

				st_cfg_rd_wait: begin
					// Read data is registered by the requester at done
					if (apb_done) begin
						cpl_start     <= 1'b1;
						cpl_with_data <= 1'b1;
						state         <= st_idle;
					end
				end

				// Wait for the last beat
				st_drop: begin
				end

				default: state <= st_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header and payload capture

	always_ff @(posedge axi_tlp_rx) begin
		if (rx_beat) begin
			case (state)
				st_idle: begin
					rx_fmt  <= pcie_tl_pkg::tlp_format_t'(tlp_in.data[7:5]);
					rx_type <= pcie_tl_pkg::tlp_type_t'(tlp_in.data[4:0]);
					rx_len  <= {tlp_in.data[17:16], tlp_in.data[31:24]};
				end
				st_hdr1: begin
					rx_requester <= tlp_in.data[15:0];
					rx_tag       <= tlp_in.data[23:16];
				end
				st_hdr2:      rx_addr   <= addr_swap;
				st_cfg_wdata: apb_wdata <= tlp_in.data;
				st_mem_wr:    mem_data  <= tlp_in.data;
				default: begin
				end
			endcase
		end
	end

	// Low 12 bits of the swapped address are the register in both directions
	assign apb_req = '{start: apb_start, write: apb_write,
		addr: rx_addr[11:0], wdata: apb_wdata};

	assign cpl_req = '{start: cpl_start, with_data: cpl_with_data, len: rx_len,
		requester: rx_requester, tag: rx_tag, cpl_id: cpl_id, rdata: apb_rdata};

	assign mem_wr = '{valid: mem_valid, last: mem_last, crc_err: mem_crc, data: mem_data};

	// Ready stays low until the generator has finished
	a_cpl_not_busy: assert property (@(posedge axi_tlp_rx) disable iff (!rst_n)
		cpl_req.start |-> !cpl_busy);

	a_no_apb_in_rd_wait: assert property (@(posedge axi_tlp_rx) disable iff (!rst_n)
		(state == st_cfg_rd_wait) |=> !apb_req.start);

endmodule

`default_nettype wire

// File: src/cfg_apb_requester.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_apb_requester (
	input  wire                                 axi_tlp_rx,
	input  wire                                 rst_n,
	input  wire pcie_tl_pkg::apb_req_t          apb_req,
	output logic                                psel,
	output logic                                penable,
	output logic                                pwrite,
	output pcie_tl_pkg::cfg_addr_t              paddr,
	output pcie_tl_pkg::tlp_word_t              pwdata,
	output logic [pcie_tl_pkg::strb_w-1:0]      pstrb,
	input  wire                                 pready,
	input  wire pcie_tl_pkg::tlp_word_t         prdata,
	output logic                                apb_done,
	output pcie_tl_pkg::tlp_word_t              apb_rdata
);

	logic launch;

	// New request only when the bus is idle
	assign launch = apb_req.start && !psel;

	// Access phase ends on the first pready
	assign apb_done = psel && penable && pready;

	// Setup, then access until pready
	always_ff @(posedge axi_tlp_rx or negedge rst_n) begin
		if (!rst_n) begin
			psel    <= 1'b0;
			penable <= 1'b0;
			pwrite  <= 1'b0;
			pstrb   <= '0;
		end else if (launch) begin
			psel    <= 1'b1;
			penable <= 1'b0;
			pwrite  <= apb_req.write;
			// Full word writes only, reads carry no strobe
			pstrb   <= apb_req.write ? '1 : '0;
		end else if (psel && !penable)
			penable <= 1'b1;
		else if (apb_done) begin
			psel    <= 1'b0;
			penable <= 1'b0;
		end
	end

	// Address and data
	always_ff @(posedge axi_tlp_rx) begin
		if (launch) begin
			paddr  <= apb_req.addr;
			pwdata <= apb_req.write ? apb_req.wdata : '0;
		end
		if (apb_done)
			apb_rdata <= prdata;
	end

	// Access phase always follows a setup cycle
	a_penable_after_setup: assert property (@(posedge axi_tlp_rx) disable iff (!rst_n)
		penable |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: src/cpl_generator.sv
`timescale 1ns/1ps
`default_nettype none

module cpl_generator (
	input  wire                             axi_tlp_rx,
	input  wire                             rst_n,
	input  wire pcie_tl_pkg::cpl_req_t      cpl_req,
	output pcie_tl_pkg::tx_stream_t         tlp_out,
	output logic                            cpl_busy
);

	// Request held for the whole completion
	pcie_tl_pkg::cpl_req_t      req_q;
	logic [1:0]                 word_idx;
	logic [11:0]                byte_count;

	pcie_tl_pkg::tlp_word_t     word_0;
	pcie_tl_pkg::tlp_word_t     word_1;
	pcie_tl_pkg::tlp_word_t     word_2;
	pcie_tl_pkg::tlp_word_t     next_word;
	logic                       next_last;

	logic                       tx_valid;
	logic                       tx_last;
	pcie_tl_pkg::tlp_word_t     tx_data;

	logic                       accept;

	assign accept = cpl_req.start && !cpl_busy;

	//////////////////////////////////////////////////////////////////////
	// Completion words, least significant byte first on the wire

	// Word 0 goes out right after the start, so built from the live request
	// Length byte is one word with data, zero without
	assign word_0 = {
		cpl_req.with_data ? 8'h01 : 8'h00,
		16'h0000,
		cpl_req.with_data ? pcie_tl_pkg::fmt_3dw_data : pcie_tl_pkg::fmt_3dw_nodata,
		pcie_tl_pkg::type_cpl
	};

	// Byte count in bytes, config reads are fixed
	assign byte_count = req_q.with_data ? 12'(pcie_tl_pkg::cfg_rd_byte_count) :
		{req_q.len, 2'b00};

	// Completer ID, zero status, split byte count
	assign word_1 = {
		byte_count[7:0],
		4'h0, byte_count[11:8],
		req_q.cpl_id.dev, 3'b000,
		req_q.cpl_id.bus
	};

	// Requester ID and tag echoed back, lower address zero
	assign word_2 = {8'h00, req_q.tag, req_q.requester};

	always_comb begin
		case (word_idx)
			2'd1:    next_word = word_1;
			2'd2:    next_word = word_2;
			default: next_word = req_q.rdata;
		endcase
	end

	// Three words without data, four with
	assign next_last = (word_idx == 2'd3) || (word_idx == 2'd2 && !req_q.with_data);

	//////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge axi_tlp_rx or negedge rst_n) begin
		if (!rst_n) begin
			cpl_busy <= 1'b0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
			word_idx <= 2'd0;
		end else if (!cpl_busy) begin
			tx_valid <= cpl_req.start;
			tx_last  <= 1'b0;
			if (cpl_req.start) begin
				cpl_busy <= 1'b1;
				word_idx <= 2'd1;
			end
		end else if (tx_last) begin
			// Last word is on the bus now, release after it
			cpl_busy <= 1'b0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
		end else begin
			tx_valid <= 1'b1;
			tx_last  <= next_last;
			word_idx <= word_idx + 2'd1;
		end
	end

	always_ff @(posedge axi_tlp_rx) begin
		if (accept) begin
			req_q   <= cpl_req;
			tx_data <= word_0;
		end else if (cpl_busy && !tx_last)
			tx_data <= next_word;
	end

	assign tlp_out = '{valid: tx_valid, last: tx_last, data: tx_data};

	// Every completion has at least three words before last
	a_last_ends_burst: assert property (@(posedge axi_tlp_rx) disable iff (!rst_n)
		tlp_out.last |-> tlp_out.valid && $past(tlp_out.valid) && $past(tlp_out.valid, 2));

endmodule

`default_nettype wire

// File: src/pcie_transaction_layer.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_transaction_layer (
	input  wire                                 axi_tlp_rx,
	input  wire                                 rst_n,

	// Receive side from the data link layer
	input  wire pcie_tl_pkg::tlp_stream_t       tlp_in,
	output logic                                tlp_in_ready,

	// Completions to the data link layer
	output pcie_tl_pkg::tx_stream_t             tlp_out,

	// Memory write payload
	output pcie_tl_pkg::tlp_stream_t            mem_wr,

	// Config space requester
	output logic                                psel,
	output logic                                penable,
	output logic                                pwrite,
	output pcie_tl_pkg::cfg_addr_t              paddr,
	output pcie_tl_pkg::tlp_word_t              pwdata,
	output logic [pcie_tl_pkg::strb_w-1:0]      pstrb,
	input  wire                                 pready,
	input  wire pcie_tl_pkg::tlp_word_t         prdata
);

	pcie_tl_pkg::apb_req_t      apb_req;
	logic                       apb_done;
	pcie_tl_pkg::tlp_word_t     apb_rdata;
	pcie_tl_pkg::cpl_req_t      cpl_req;
	logic                       cpl_busy;

	// Header decode and routing
	tlp_rx_parser u_parser (
		.axi_tlp_rx   (axi_tlp_rx),
		.rst_n        (rst_n),
		.tlp_in       (tlp_in),
		.tlp_in_ready (tlp_in_ready),
		.mem_wr       (mem_wr),
		.apb_req      (apb_req),
		.apb_done     (apb_done),
		.apb_rdata    (apb_rdata),
		.cpl_req      (cpl_req),
		.cpl_busy     (cpl_busy)
	);

	// Config reads and writes
	cfg_apb_requester u_apb (
		.axi_tlp_rx (axi_tlp_rx),
		.rst_n      (rst_n),
		.apb_req    (apb_req),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pstrb      (pstrb),
		.pready     (pready),
		.prdata     (prdata),
		.apb_done   (apb_done),
		.apb_rdata  (apb_rdata)
	);

	// Completions for every accepted request
	cpl_generator u_cpl (
		.axi_tlp_rx (axi_tlp_rx),
		.rst_n      (rst_n),
		.cpl_req    (cpl_req),
		.tlp_out    (tlp_out),
		.cpl_busy   (cpl_busy)
	);

endmodule

`default_nettype wire

// File: verif/tb_pcie_tl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_tl;

	typedef struct packed {
		logic                              wr;
		pcie_tl_pkg::cfg_addr_t            addr;
		pcie_tl_pkg::tlp_word_t            data;
		logic [pcie_tl_pkg::strb_w-1:0]    strb;
	} apb_rec_t;

	localparam int cls_cfg_wr = 0;
	localparam int cls_cfg_rd = 1;
	localparam int cls_mem_wr = 2;
	localparam int cls_drop   = 3;
	localparam int timeout    = 200;

	logic                                 axi_tlp_rx;
	logic                                 rst_n;
	pcie_tl_pkg::tlp_stream_t             tlp_in;
	logic                                 tlp_in_ready;
	pcie_tl_pkg::tx_stream_t              tlp_out;
	pcie_tl_pkg::tlp_stream_t             mem_wr;
	logic                                 psel;
	logic                                 penable;
	logic                                 pwrite;
	pcie_tl_pkg::cfg_addr_t               paddr;
	pcie_tl_pkg::tlp_word_t               pwdata;
	logic [pcie_tl_pkg::strb_w-1:0]       pstrb;
	logic                                 pready;
	pcie_tl_pkg::tlp_word_t               prdata;

	// Marks payload beats for the acceptance monitor
	logic                                 in_payload;
	int                                   cyc;
	int                                   wait_cnt;

	// Stimulus table
	logic [31:0]  t_hdr0[$];
	logic [31:0]  t_hdr1[$];
	logic [31:0]  t_hdr2[$];
	int           t_npay[$];
	logic         t_crc[$];
	int           t_cls[$];

	// Observed traffic
	pcie_tl_pkg::tx_stream_t    tx_q[$];
	int                         tx_cyc_q[$];
	pcie_tl_pkg::tlp_stream_t   mem_q[$];
	int                         mem_cyc_q[$];
	int                         acc_cyc_q[$];
	apb_rec_t                   apb_q[$];
	pcie_tl_pkg::tlp_word_t     rd_q[$];

	pcie_transaction_layer UUT (
		.axi_tlp_rx   (axi_tlp_rx),
		.rst_n        (rst_n),
		.tlp_in       (tlp_in),
		.tlp_in_ready (tlp_in_ready),
		.tlp_out      (tlp_out),
		.mem_wr       (mem_wr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pstrb        (pstrb),
		.pready       (pready),
		.prdata       (prdata)
	);

	always #50 axi_tlp_rx = ~axi_tlp_rx;

	always @(posedge axi_tlp_rx)
		cyc <= cyc + 1;

	//////////////////////////////////////////////////////////////////////
	// APB responder, 0 to 3 wait cycles per access

	always @(posedge axi_tlp_rx) begin
		#1;
		if (psel && penable && !pready) begin
			if (wait_cnt == 0) begin
				pready = 1'b1;
				prdata = $urandom;
				if (!pwrite)
					rd_q.push_back(prdata);
			end else
				wait_cnt = wait_cnt - 1;
		end else begin
			pready = 1'b0;
			wait_cnt = $urandom % 4;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Monitors, sampled mid-cycle where everything is stable

	always @(negedge axi_tlp_rx) begin
		if (rst_n) begin
			if (tlp_out.valid) begin
				tx_q.push_back(tlp_out);
				tx_cyc_q.push_back(cyc);
			end
			if (mem_wr.valid) begin
				mem_q.push_back(mem_wr);
				mem_cyc_q.push_back(cyc);
			end
			if (tlp_in.valid && tlp_in_ready && in_payload)
				acc_cyc_q.push_back(cyc);
			if (psel && penable && pready)
				apb_q.push_back('{wr: pwrite, addr: paddr, data: pwdata, strb: pstrb});
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Error reporting and compare tasks

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_tx_word(input pcie_tl_pkg::tx_stream_t got,
		input pcie_tl_pkg::tx_stream_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_mem_beat(input pcie_tl_pkg::tlp_stream_t got,
		input pcie_tl_pkg::tlp_stream_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	// Write data only matters on writes
	task automatic check_apb(input apb_rec_t got, input logic wr,
		input pcie_tl_pkg::cfg_addr_t addr, input pcie_tl_pkg::tlp_word_t data);
		logic [pcie_tl_pkg::strb_w-1:0] strb;
		strb = wr ? '1 : '0;
		if (got.wr !== wr || got.addr !== addr || got.strb !== strb ||
			(wr && got.data !== data))
			stop_on_error($sformatf("mismatch at %0t: apb access got %h expected %b %h %h %h",
				$time, got, wr, addr, data, strb));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	task automatic add_case(input logic [31:0] h0, input logic [31:0] h1,
		input logic [31:0] h2, input int npay, input logic crc, input int cls);
		t_hdr0.push_back(h0);
		t_hdr1.push_back(h1);
		t_hdr2.push_back(h2);
		t_npay.push_back(npay);
		t_crc.push_back(crc);
		t_cls.push_back(cls);
	endtask

	// Ready is registered, so its level now holds at the next edge
	task automatic send_beat(input logic [31:0] data, input logic last,
		input logic crc, input logic pay);
		int t;
		t = 0;
		while (!tlp_in_ready) begin
			@(posedge axi_tlp_rx);
			#1;
			t = t + 1;
			if (t > timeout)
				stop_on_error("timeout waiting for tlp_in_ready before a beat");
		end
		tlp_in = '{valid: 1'b1, last: last, crc_err: crc, data: data};
		in_payload = pay;
		@(posedge axi_tlp_rx);
		#1;
		tlp_in = '0;
		in_payload = 1'b0;
	endtask

	task automatic wait_count(input int n, input int which, input string what);
		int t;
		t = 0;
		while ((which == 0 ? tx_q.size() : which == 1 ? mem_q.size() : apb_q.size()) < n) begin
			@(posedge axi_tlp_rx);
			#1;
			t = t + 1;
			if (t > timeout)
				stop_on_error({"timeout waiting for ", what});
		end
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (!tlp_in_ready) begin
			@(posedge axi_tlp_rx);
			#1;
			t = t + 1;
			if (t > timeout)
				stop_on_error("timeout waiting for tlp_in_ready after a TLP");
		end
	endtask

	task automatic check_idle_queues(input string where);
		if (tx_q.size() != 0 || mem_q.size() != 0 || apb_q.size() != 0)
			stop_on_error($sformatf("unexpected output traffic %s: tx %0d mem %0d apb %0d",
				where, tx_q.size(), mem_q.size(), apb_q.size()));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		pcie_tl_pkg::tlp_word_t   pay[$];
		pcie_tl_pkg::tlp_word_t   exp_words[$];
		pcie_tl_pkg::tx_stream_t  got_tx;
		apb_rec_t                 rec;
		logic [9:0]               len;
		logic [15:0]              req_id;
		logic [7:0]               tag;
		logic [31:0]              swapped;
		logic [7:0]               exp_bus;
		logic [4:0]               exp_dev;
		logic [11:0]              bc;
		logic                     with_data;
		logic                     last;
		int                       n;
		int                       c0;

		void'($urandom(32'h118));
		axi_tlp_rx = 1'b0;
		rst_n = 1'b0;
		tlp_in = '0;
		in_payload = 1'b0;
		pready = 1'b0;
		prdata = '0;
		wait_cnt = 0;
		cyc = 0;
		exp_bus = 8'h00;
		exp_dev = 5'h00;

		// Config read first, so its completion shows the reset completer ID
		add_case(32'h0100_0004, 32'h005A_1234, 32'hC803_0000, 0, 1'b0, cls_cfg_rd);
		add_case(32'h0100_0044, 32'h0011_BEEF, 32'h1002_283A, 1, 1'b0, cls_cfg_wr);
		add_case(32'h0100_0004, 32'h0007_0042, 32'h0401_0000, 0, 1'b0, cls_cfg_rd);
		add_case(32'h0400_0040, 32'h0022_ABCD, 32'h0000_1000, 4, 1'b0, cls_mem_wr);
		// Poisoned, 4DW, unknown type, bad CRC, data beat without last
		add_case(32'h0140_0044, 32'h0001_0001, 32'h0000_0801, 1, 1'b0, cls_drop);
		add_case(32'h0100_0060, 32'h0002_0002, 32'h0000_2000, 2, 1'b0, cls_drop);
		add_case(32'h0100_0047, 32'h0003_0003, 32'h0000_3000, 1, 1'b0, cls_drop);
		add_case(32'h0100_0044, 32'h0004_0004, 32'h0000_1055, 1, 1'b1, cls_drop);
		add_case(32'h0100_0044, 32'h0005_0005, 32'h0000_1066, 2, 1'b0, cls_drop);
		add_case(32'h0100_0044, 32'h0033_4321, 32'h0000_F877, 1, 1'b0, cls_cfg_wr);
		add_case(32'h0200_0040, 32'h0044_5555, 32'h0000_4000, 2, 1'b1, cls_mem_wr);
		add_case(32'h0100_0004, 32'h0099_0A0B, 32'hFF0F_0000, 0, 1'b0, cls_cfg_rd);

		repeat (4) @(posedge axi_tlp_rx);
		#1;
		rst_n = 1'b1;
		@(negedge axi_tlp_rx);
		check_level(tlp_in_ready, 1'b1, "tlp_in_ready after reset");
		check_level(tlp_out.valid, 1'b0, "tlp_out.valid after reset");
		check_level(mem_wr.valid, 1'b0, "mem_wr.valid after reset");
		check_level(psel, 1'b0, "psel after reset");
		check_level(penable, 1'b0, "penable after reset");
		@(posedge axi_tlp_rx);
		#1;

		for (int i = 0; i < t_cls.size(); i++) begin
			check_idle_queues($sformatf("before case %0d", i));
			acc_cyc_q.delete();
			len = {t_hdr0[i][17:16], t_hdr0[i][31:24]};
			req_id = t_hdr1[i][15:0];
			tag = t_hdr1[i][23:16];
			swapped = {t_hdr2[i][7:0], t_hdr2[i][15:8], t_hdr2[i][23:16], t_hdr2[i][31:24]};
			pay.delete();
			for (int k = 0; k < t_npay[i]; k++)
				pay.push_back($urandom);

			// Header then payload, last and CRC flag on the final beat
			send_beat(t_hdr0[i], 1'b0, 1'b0, 1'b0);
			send_beat(t_hdr1[i], 1'b0, 1'b0, 1'b0);
			send_beat(t_hdr2[i], t_npay[i] == 0, t_npay[i] == 0 ? t_crc[i] : 1'b0, 1'b0);
			for (int k = 0; k < t_npay[i]; k++) begin
				last = (k == t_npay[i] - 1);
				send_beat(pay[k], last, last ? t_crc[i] : 1'b0, 1'b1);
			end

			with_data = 1'b0;
			bc = {len, 2'b00};
			exp_words.delete();
			case (t_cls[i])
				cls_cfg_wr: begin
					wait_count(1, 2, "apb write");
					rec = apb_q.pop_front();
					check_apb(rec, 1'b1, swapped[11:0], pay[0]);
					exp_bus = t_hdr2[i][7:0];
					exp_dev = t_hdr2[i][15:11];
				end
				cls_cfg_rd: begin
					wait_count(1, 2, "apb read");
					rec = apb_q.pop_front();
					check_apb(rec, 1'b0, swapped[11:0], '0);
					with_data = 1'b1;
					bc = 12'd4;
				end
				cls_mem_wr: begin
					wait_count(t_npay[i], 1, "memory write beats");
					for (int k = 0; k < t_npay[i]; k++) begin
						last = (k == t_npay[i] - 1);
						check_mem_beat(mem_q.pop_front(), '{valid: 1'b1, last: last,
							crc_err: last ? t_crc[i] : 1'b0, data: pay[k]},
							$sformatf("case %0d memory beat %0d", i, k));
						if (mem_cyc_q.pop_front() != acc_cyc_q.pop_front() + 1)
							stop_on_error($sformatf("mismatch at %0t: case %0d beat %0d %s",
								$time, i, k, "not forwarded one cycle after acceptance"));
					end
				end
				default: begin
				end
			endcase

			if (t_cls[i] != cls_drop) begin
				// Completion bytes, least significant first
				exp_words.push_back({with_data ? 8'h01 : 8'h00, 16'h0000,
					with_data ? 3'd2 : 3'd0, 5'd10});
				exp_words.push_back({bc[7:0], 4'h0, bc[11:8], exp_dev, 3'b000, exp_bus});
				exp_words.push_back({8'h00, tag, req_id});
				if (with_data)
					exp_words.push_back(rd_q.pop_front());
				n = exp_words.size();
				wait_count(n, 0, "completion words");
				c0 = tx_cyc_q[0];
				for (int k = 0; k < n; k++) begin
					got_tx = tx_q.pop_front();
					check_tx_word(got_tx, '{valid: 1'b1, last: k == n - 1, data: exp_words[k]},
						$sformatf("case %0d completion word %0d", i, k));
					if (tx_cyc_q.pop_front() != c0 + k)
						stop_on_error($sformatf("mismatch at %0t: case %0d word %0d %s",
							$time, i, k, "completion words not back to back"));
				end
			end
			wait_ready();
		end

		// Let any stray output from the last TLP show up
		repeat (10) @(posedge axi_tlp_rx);
		#1;
		check_idle_queues("at end of run");

		$display("TESTS PASSED");
		$finish;
	end

	// Run limit for the whole simulation
	initial begin
		#2ms;
		$display("simulation ran past its time limit");
		$display("TESTS FAILED");
		$fatal(1, "time limit reached");
	end

endmodule

`default_nettype wire

// File: compile.f
src/pcie_tl_pkg.sv
src/tlp_rx_parser.sv
src/cfg_apb_requester.sv
src/cpl_generator.sv
src/pcie_transaction_layer.sv
verif/tb_pcie_tl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pcie_tl
FILELIST  = compile.f
LOG       = sim.log
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
